//--- Makefile
VERILATOR ?= verilator
TOP       ?= tinker_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -Wall
FILELIST  ?= sources.f

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q "^ALL TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/tinker_tb.sv
// Tinker system testbench
module tinker_tb;
    import tinker_isa_pkg::*;
    import tinker_bus_pkg::*;

    // Instructions and APB transfers over all tests, with margin
    localparam int INSTR_TOTAL = 200;
    localparam int APB_TOTAL   = 300;
    localparam int CYCLE_LIMIT = (INSTR_TOTAL * 5 + APB_TOTAL * 2) * 2;

    logic        clk;
    logic        reset;
    apb_req_t    req;
    apb_rsp_t    rsp;
    logic        halted;
    integer      seed = 32'hd25e;
    int          cycle_count = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] prog [$];

    tinker_system i_dut (.clk, .reset, .apb_req(req), .apb_rsp(rsp), .halted);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // APB transfers, entered at edge plus one
    // ----------------------------------------
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        #1 req.penable = 1'b1;
        @(negedge clk);
        err = rsp.pslverr;
        check_value("apb write pready", 1, rsp.pready);
        @(posedge clk);
        #1 req = '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge clk);
        #1 req.penable = 1'b1;
        @(negedge clk);
        data = rsp.prdata;
        err  = rsp.pslverr;
        check_value("apb read pready", 1, rsp.pready);
        @(posedge clk);
        #1 req = '0;
    endtask

    task automatic read_reg(input int idx, output logic [63:0] value);
        logic        err;
        logic [31:0] lo;
        logic [31:0] hi;
        apb_write(REG_SEL, idx, err);
        apb_read(REG_DATA_LO, lo, err);
        apb_read(REG_DATA_HI, hi, err);
        value = {hi, lo};
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (exp === act) else begin
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input int idx, input logic [63:0] exp);
        logic [63:0] act;
        read_reg(idx, act);
        check_value($sformatf("%s r%0d", name, idx), exp, act);
    endtask

    // ----------------------------------------
    // Program building
    // ----------------------------------------
    function automatic logic [31:0] encode(opcode_e op, int rd, int rs, int rt, logic [11:0] lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), lit};
    endfunction

    function automatic void emit(opcode_e op, int rd, int rs, int rt, logic [11:0] lit);
        prog.push_back(encode(op, rd, rs, rt, lit));
    endfunction

    // Clear, then build the value 12 bits at a time from the top
    function automatic void emit_const(int rd, logic [63:0] value);
        emit(OP_XOR, rd, rd, rd, 0);
        emit(OP_MOVL, rd, 0, 0, {8'd0, value[63:60]});
        for (int k = 4; k >= 0; k--) begin
            emit(OP_SHFTLI, rd, 0, 0, 12);
            emit(OP_MOVL, rd, 0, 0, value[12*k +: 12]);
        end
    endfunction

    function automatic void emit_addr(int rd, int index);
        logic [15:0] addr;
        addr = 16'h2000 + 16'(4 * index);
        emit(OP_XOR, rd, rd, rd, 0);
        emit(OP_MOVL, rd, 0, 0, {8'd0, addr[15:12]});
        emit(OP_SHFTLI, rd, 0, 0, 12);
        emit(OP_MOVL, rd, 0, 0, addr[11:0]);
    endfunction

    task automatic load_program();
        logic err;
        apb_write(REG_MEM_ADDR, 32'h2000, err);
        foreach (prog[i]) apb_write(REG_MEM_DATA, prog[i], err);
    endtask

    task automatic wait_halted();
        while (!halted) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        $display("test %-12s %s", name, (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] rdata;
        logic [5:0]  sh;
        logic        err;
        int          e0;
        int          add_idx;

        req   = '0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        // Reset state
        e0 = errors;
        check_value("reset halted pin", 0, halted);
        apb_read(REG_CTRL, rdata, err);
        check_value("reset status", 0, rdata);
        check_value("reset status pslverr", 0, err);
        check_reg("reset", 31, 64'h80000);
        check_reg("reset", 5, 0);
        apb_read(8'h20, rdata, err);
        check_value("unmapped pslverr", 1, err);
        check_value("unmapped read data", 0, rdata);
        finish_test("reset", e0);

        // Arithmetic and logic
        e0 = errors;
        a = {$random(seed), $random(seed)};
        b = {$random(seed), $random(seed)};
        prog.delete();
        emit_const(1, a);
        emit_const(2, b);
        add_idx = prog.size();
        emit(OP_ADD, 3, 1, 2, 0);
        emit(OP_MOV, 4, 1, 0, 0);
        emit(OP_ADDI, 4, 0, 0, 12'hF9C);   // -100
        emit(OP_SUB, 5, 1, 2, 0);
        emit(OP_MOV, 6, 1, 0, 0);
        emit(OP_SUBI, 6, 0, 0, 12'h123);
        emit(OP_AND, 7, 1, 2, 0);
        emit(OP_OR, 8, 1, 2, 0);
        emit(OP_XOR, 9, 1, 2, 0);
        emit(OP_NOT, 10, 1, 0, 0);
        emit(OP_HALT, 0, 0, 0, 0);
        load_program();
        apb_write(REG_CTRL, 1, err);
        wait_halted();
        for (int run = 0; run < 2; run++) begin
            check_reg("arith", 3, a + b);
            check_reg("arith", 4, a - 64'd100);
            check_reg("arith", 5, a - b);
            check_reg("arith", 6, a - 64'h123);
            check_reg("arith", 7, a & b);
            check_reg("arith", 8, a | b);
            check_reg("arith", 9, a ^ b);
            check_reg("arith", 10, ~a);
            if (run == 0) begin
                finish_test("arith", e0);
                // Halt and refusal, same program again
                e0 = errors;
                apb_write(REG_CTRL, 1, err);
                check_value("restart pslverr", 0, err);
                // Aimed at the add, which would then clear r3
                apb_write(REG_MEM_ADDR, 32'h2000 + 32'(4 * add_idx), err);
                apb_write(REG_MEM_DATA, encode(OP_XOR, 3, 3, 3, 0), err);
                check_value("load while running pslverr", 1, err);
                check_value("halted pin while running", 0, halted);
                wait_halted();
                apb_read(REG_CTRL, rdata, err);
                check_value("halted status", 2, rdata);
            end
        end
        finish_test("halt", e0);

        // Shifts and moves
        e0 = errors;
        a  = {$random(seed), $random(seed)};
        sh = $random(seed);
        prog.delete();
        emit_const(1, a);
        emit(OP_XOR, 12, 12, 12, 0);
        emit(OP_MOVL, 12, 0, 0, {6'd0, sh});
        emit(OP_SHFTR, 13, 1, 12, 0);
        emit(OP_MOV, 14, 1, 0, 0);
        emit(OP_SHFTRI, 14, 0, 0, 7);
        emit(OP_SHFTL, 15, 1, 12, 0);
        emit(OP_MOV, 16, 1, 0, 0);
        emit(OP_SHFTLI, 16, 0, 0, 13);
        emit(OP_MOV, 17, 1, 0, 0);
        emit(OP_MOVL, 17, 0, 0, 12'hABC);
        emit(OP_MOV, 0, 1, 0, 0);
        emit(OP_HALT, 0, 0, 0, 0);
        load_program();
        apb_write(REG_CTRL, 1, err);
        wait_halted();
        check_reg("shift", 13, a >> sh);
        check_reg("shift", 14, a >> 7);
        check_reg("shift", 15, a << sh);
        check_reg("shift", 16, a << 13);
        check_reg("move", 17, {a[63:12], 12'hABC});
        check_reg("move", 0, 0);
        finish_test("shift_move", e0);

        // Load and store, data area at 0x4000
        e0 = errors;
        a  = {$random(seed), $random(seed)};
        w1 = $random(seed);
        w2 = $random(seed);
        prog.delete();
        emit_const(1, a);
        emit(OP_XOR, 20, 20, 20, 0);
        emit(OP_MOVL, 20, 0, 0, 4);
        emit(OP_SHFTLI, 20, 0, 0, 12);
        emit(OP_STORE, 1, 20, 0, 8);
        emit(OP_LOAD, 21, 20, 0, 8);
        emit(OP_LOAD, 22, 20, 0, 12'h100);
        emit(OP_HALT, 0, 0, 0, 0);
        load_program();
        apb_write(REG_MEM_ADDR, 32'h4100, err);
        apb_write(REG_MEM_DATA, w1, err);
        apb_write(REG_MEM_DATA, w2, err);
        apb_write(REG_CTRL, 1, err);
        wait_halted();
        check_reg("load", 21, a);
        check_reg("load", 22, {w1, w2});
        finish_test("load_store", e0);

        // Branches, right paths add 1 to r25, wrong ones 0x100
        e0 = errors;
        prog.delete();
        emit(OP_XOR, 25, 25, 25, 0);        // 0
        emit_addr(26, 7);                   // 1..4
        emit(OP_BR, 26, 0, 0, 0);           // 5
        emit(OP_ADDI, 25, 0, 0, 12'h100);
        emit(OP_ADDI, 25, 0, 0, 1);         // 7
        emit(OP_XOR, 27, 27, 27, 0);
        emit(OP_MOVL, 27, 0, 0, 8);
        emit(OP_BRR, 27, 0, 0, 0);          // 10, to 12
        emit(OP_ADDI, 25, 0, 0, 12'h100);
        emit(OP_ADDI, 25, 0, 0, 1);         // 12
        emit(OP_BRRL, 0, 0, 0, 8);          // 13, to 15
        emit(OP_ADDI, 25, 0, 0, 12'h100);
        emit(OP_ADDI, 25, 0, 0, 1);         // 15
        emit(OP_XOR, 28, 28, 28, 0);
        emit(OP_MOVL, 28, 0, 0, 5);
        emit_addr(26, 24);                  // 18..21
        emit(OP_BRNZ, 26, 28, 0, 0);        // 22 taken
        emit(OP_ADDI, 25, 0, 0, 12'h100);
        emit(OP_ADDI, 25, 0, 0, 1);         // 24
        emit(OP_BRNZ, 26, 0, 0, 0);         // 25 not taken
        emit(OP_ADDI, 25, 0, 0, 1);
        emit(OP_XOR, 29, 29, 29, 0);        // 27
        emit(OP_MOVL, 29, 0, 0, 5);
        emit(OP_XOR, 30, 30, 30, 0);
        emit(OP_NOT, 30, 30, 0, 0);         // r30 = -1
        emit_addr(26, 37);                  // 31..34
        emit(OP_BRGT, 26, 29, 30, 0);       // 35, 5 > -1
        emit(OP_ADDI, 25, 0, 0, 12'h100);
        emit(OP_ADDI, 25, 0, 0, 1);         // 37
        emit(OP_BRGT, 26, 30, 29, 0);       // -1 > 5 is false
        emit(OP_ADDI, 25, 0, 0, 1);
        emit(OP_HALT, 0, 0, 0, 0);
        load_program();
        apb_write(REG_CTRL, 1, err);
        wait_halted();
        check_reg("branch marker", 25, 7);
        finish_test("branch", e0);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- hw/host_apb_port.sv
// APB host port
module host_apb_port (
    input  logic                                 clk,
    input  logic                                 reset,
    input  tinker_bus_pkg::apb_req_t             apb_req,
    output tinker_bus_pkg::apb_rsp_t             apb_rsp,
    input  tinker_isa_pkg::core_state_e          state,
    output logic                                 start,
    output tinker_bus_pkg::mem_wr_t              mem_wr,
    output logic [tinker_isa_pkg::REG_IDX_W-1:0] host_idx,
    input  logic [tinker_isa_pkg::XLEN-1:0]      host_data
);
    import tinker_isa_pkg::*;
    import tinker_bus_pkg::*;

    logic                 access;
    logic                 wr_access;
    logic                 rd_access;
    logic                 running;
    logic                 core_halted;
    logic                 mapped;
    logic                 start_req;
    logic                 load_req;
    logic [31:0]          mem_addr;
    logic [REG_IDX_W-1:0] reg_sel;
    logic [APB_DW-1:0]    rd_data;

    assign access      = apb_req.psel && apb_req.penable;
    assign wr_access   = access && apb_req.pwrite;
    assign rd_access   = access && !apb_req.pwrite;
    assign core_halted = (state == ST_HALTED);
    assign running     = (state != ST_IDLE) && !core_halted;

    always_comb begin
        case (apb_req.paddr)
            REG_CTRL, REG_MEM_ADDR, REG_MEM_DATA,
            REG_SEL, REG_DATA_LO, REG_DATA_HI: mapped = 1'b1;
            default: mapped = 1'b0;
        endcase
    end

    assign start_req = wr_access && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[0];
    assign load_req  = wr_access && (apb_req.paddr == REG_MEM_DATA);

    // Both refused while the core runs
    assign start       = start_req && !running;
    assign mem_wr.en   = load_req && !running;
    assign mem_wr.addr = mem_addr;
    assign mem_wr.data = apb_req.pwdata;

    // ----------------------------------------
    // Address and select registers
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_addr <= '0;
            reg_sel  <= '0;
        end else begin
            if (wr_access && (apb_req.paddr == REG_MEM_ADDR)) begin
                mem_addr <= apb_req.pwdata;
            end else if (mem_wr.en) begin
                mem_addr <= mem_addr + 32'd4;   // Next word
            end
            if (wr_access && (apb_req.paddr == REG_SEL)) begin
                reg_sel <= apb_req.pwdata[REG_IDX_W-1:0];
            end
        end
    end

    assign host_idx = reg_sel;

    always_comb begin
        rd_data = '0;
        if (rd_access) begin
            case (apb_req.paddr)
                REG_CTRL:     rd_data = {30'd0, core_halted, running};
                REG_MEM_ADDR: rd_data = mem_addr;
                REG_SEL:      rd_data = {{(APB_DW-REG_IDX_W){1'b0}}, reg_sel};
                REG_DATA_LO:  rd_data = host_data[31:0];
                REG_DATA_HI:  rd_data = host_data[63:32];
                default:      rd_data = '0;
            endcase
        end
    end

    assign apb_rsp.pready  = 1'b1;   // Never stalls
    assign apb_rsp.pslverr = (access && !mapped) || ((start_req || load_req) && running);
    assign apb_rsp.prdata  = rd_data;

endmodule

//--- hw/tinker_alu.sv
// Tinker integer ALU
module tinker_alu (
    input  tinker_isa_pkg::opcode_e          opcode,
    input  logic [tinker_isa_pkg::XLEN-1:0]  op_a,
    input  logic [tinker_isa_pkg::XLEN-1:0]  op_b,
    input  logic [tinker_isa_pkg::LIT_W-1:0] lit,
    output logic [tinker_isa_pkg::XLEN-1:0]  result
);
    import tinker_isa_pkg::*;

    logic [XLEN-1:0] lit_sext;
    logic [XLEN-1:0] lit_zext;

    assign lit_sext = {{(XLEN-LIT_W){lit[LIT_W-1]}}, lit};
    assign lit_zext = {{(XLEN-LIT_W){1'b0}}, lit};

    always_comb begin
        case (opcode)
            // ----------------------------------------
            // Integer
            // ----------------------------------------
            OP_ADD:    result = op_a + op_b;
            OP_ADDI:   result = op_a + lit_sext;
            OP_SUB:    result = op_a - op_b;
            OP_SUBI:   result = op_a - lit_zext;   // Unsigned literal
            // ----------------------------------------
            // Logic and shifts
            // ----------------------------------------
            OP_AND:    result = op_a & op_b;
            OP_OR:     result = op_a | op_b;
            OP_XOR:    result = op_a ^ op_b;
            OP_NOT:    result = ~op_a;
            OP_SHFTR:  result = op_a >> op_b;
            OP_SHFTRI: result = op_a >> lit;
            OP_SHFTL:  result = op_a << op_b;
            OP_SHFTLI: result = op_a << lit;
            // Moves
            OP_MOV:    result = op_a;
            OP_MOVL:   result = {op_a[XLEN-1:LIT_W], lit};  // Only the low bits change
            default:   result = '0;
        endcase
    end

endmodule

//--- hw/tinker_bus_pkg.sv
// Host bus types and register map
package tinker_bus_pkg;

    localparam int APB_AW = 8;
    localparam int APB_DW = 32;

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------
    localparam logic [APB_AW-1:0] REG_CTRL     = 8'h00;  // W bit 0 start, R running/halted
    localparam logic [APB_AW-1:0] REG_MEM_ADDR = 8'h04;
    localparam logic [APB_AW-1:0] REG_MEM_DATA = 8'h08;  // Write only
    localparam logic [APB_AW-1:0] REG_SEL      = 8'h0C;
    localparam logic [APB_AW-1:0] REG_DATA_LO  = 8'h10;
    localparam logic [APB_AW-1:0] REG_DATA_HI  = 8'h14;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [APB_DW-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic              pready;
        logic              pslverr;
        logic [APB_DW-1:0] prdata;
    } apb_rsp_t;

    // One big-endian word from the host into memory
    typedef struct packed {
        logic              en;
        logic [31:0]       addr;
        logic [APB_DW-1:0] data;
    } mem_wr_t;

endpackage

//--- hw/tinker_isa_pkg.sv
// Tinker instruction set definitions
package tinker_isa_pkg;

    localparam int XLEN      = 64;
    localparam int ILEN      = 32;
    localparam int ADDR_W    = 32;
    localparam int REG_IDX_W = 5;
    localparam int LIT_W     = 12;
    localparam int NUM_REGS  = 32;
    localparam int MEM_BYTES = 65536;
    localparam int MEM_AW    = $clog2(MEM_BYTES);   // Byte index width

    localparam logic [ADDR_W-1:0] RESET_PC = 32'h0000_2000;
    localparam logic [XLEN-1:0]   SP_RESET = 64'h0000_0000_0008_0000;  // Initial r31

    typedef enum logic [4:0] {
        OP_AND    = 5'h00,
        OP_OR     = 5'h01,
        OP_XOR    = 5'h02,
        OP_NOT    = 5'h03,
        OP_SHFTR  = 5'h04,
        OP_SHFTRI = 5'h05,
        OP_SHFTL  = 5'h06,
        OP_SHFTLI = 5'h07,
        OP_BR     = 5'h08,
        OP_BRR    = 5'h09,
        OP_BRRL   = 5'h0A,
        OP_BRNZ   = 5'h0B,
        OP_BRGT   = 5'h0E,
        OP_HALT   = 5'h0F,
        OP_LOAD   = 5'h10,
        OP_MOV    = 5'h11,
        OP_MOVL   = 5'h12,
        OP_STORE  = 5'h13,
        OP_ADD    = 5'h18,
        OP_ADDI   = 5'h19,
        OP_SUB    = 5'h1A,
        OP_SUBI   = 5'h1B
    } opcode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK,
        ST_HALTED
    } core_state_e;

    // Instruction word layout, opcode in the top bits
    typedef struct packed {
        opcode_e              opcode;
        logic [REG_IDX_W-1:0] rd;
        logic [REG_IDX_W-1:0] rs;
        logic [REG_IDX_W-1:0] rt;
        logic [LIT_W-1:0]     lit;
    } instr_t;

endpackage

//--- hw/tinker_memory.sv
// Big-endian byte memory
module tinker_memory (
    input  logic                              clk,
    input  logic [tinker_isa_pkg::ADDR_W-1:0] pc,
    output tinker_isa_pkg::instr_t            instr,
    input  logic [tinker_isa_pkg::ADDR_W-1:0] data_addr,
    output logic [tinker_isa_pkg::XLEN-1:0]   load_data,
    input  logic                              store_en,
    input  logic [tinker_isa_pkg::XLEN-1:0]   store_data,
    input  tinker_bus_pkg::mem_wr_t           mem_wr
);
    import tinker_isa_pkg::*;

    logic [7:0]        mem [MEM_BYTES];
    logic [MEM_AW-1:0] fetch_idx;
    logic [MEM_AW-1:0] data_idx;
    logic [MEM_AW-1:0] host_idx;
    logic [ILEN-1:0]   fetch_word;

    // Upper address bits wrap
    assign fetch_idx = pc[MEM_AW-1:0];
    assign data_idx  = data_addr[MEM_AW-1:0];
    assign host_idx  = mem_wr.addr[MEM_AW-1:0];

    // ----------------------------------------
    // Reads, first byte is most significant
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            fetch_word[ILEN-1-8*i -: 8] = mem[fetch_idx + MEM_AW'(i)];
        end
    end

    assign instr = fetch_word;

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            load_data[XLEN-1-8*i -: 8] = mem[data_idx + MEM_AW'(i)];
        end
    end

    // ----------------------------------------
    // Writes
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (store_en) begin
            for (int i = 0; i < 8; i++) begin
                mem[data_idx + MEM_AW'(i)] <= store_data[XLEN-1-8*i -: 8];
            end
        end
        if (mem_wr.en) begin  // Host only loads while the core is stopped
            for (int i = 0; i < 4; i++) begin
                mem[host_idx + MEM_AW'(i)] <= mem_wr.data[31-8*i -: 8];
            end
        end
    end

endmodule

//--- hw/tinker_regfile.sv
// Tinker register file
module tinker_regfile (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic [tinker_isa_pkg::REG_IDX_W-1:0] idx_a,
    input  logic [tinker_isa_pkg::REG_IDX_W-1:0] idx_b,
    input  logic [tinker_isa_pkg::REG_IDX_W-1:0] host_idx,
    output logic [tinker_isa_pkg::XLEN-1:0]      op_a,
    output logic [tinker_isa_pkg::XLEN-1:0]      op_b,
    output logic [tinker_isa_pkg::XLEN-1:0]      host_data,
    input  logic                                 wb_en,
    input  logic [tinker_isa_pkg::REG_IDX_W-1:0] wb_idx,
    input  logic [tinker_isa_pkg::XLEN-1:0]      wb_data
);
    import tinker_isa_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= (i == NUM_REGS - 1) ? SP_RESET : '0;  // r31 is the stack pointer
            end
        end else if (wb_en) begin
            regs[wb_idx] <= wb_data;
        end
    end

    // Three independent read ports
    assign op_a      = regs[idx_a];
    assign op_b      = regs[idx_b];
    assign host_data = regs[host_idx];

endmodule

//--- hw/tinker_sequencer.sv
// Multicycle Tinker sequencer
module tinker_sequencer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 start,
    input  tinker_isa_pkg::instr_t               instr,
    output logic [tinker_isa_pkg::ADDR_W-1:0]    pc,
    output tinker_isa_pkg::core_state_e          state,
    output logic [tinker_isa_pkg::REG_IDX_W-1:0] idx_a,
    output logic [tinker_isa_pkg::REG_IDX_W-1:0] idx_b,
    input  logic [tinker_isa_pkg::XLEN-1:0]      op_a,
    input  logic [tinker_isa_pkg::XLEN-1:0]      op_b,
    input  logic [tinker_isa_pkg::XLEN-1:0]      alu_result,
    input  logic [tinker_isa_pkg::XLEN-1:0]      load_data,
    output logic [tinker_isa_pkg::ADDR_W-1:0]    data_addr,
    output logic                                 store_en,
    output logic [tinker_isa_pkg::XLEN-1:0]      store_data,
    output logic                                 wb_en,
    output logic [tinker_isa_pkg::REG_IDX_W-1:0] wb_idx,
    output logic [tinker_isa_pkg::XLEN-1:0]      wb_data,
    output logic                                 halted
);
    import tinker_isa_pkg::*;

    instr_t            ir;         // Valid from execute on
    logic [XLEN-1:0]   result_q;
    logic              taken_q;
    logic              branch_cond;
    logic              writes_rd;
    logic [XLEN-1:0]   lit_ext;
    logic [ADDR_W-1:0] pc_plus4;
    logic [ADDR_W-1:0] next_pc;

    // ----------------------------------------
    // State and PC
    // ----------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            pc    <= RESET_PC;
        end else begin
            case (state)
                ST_IDLE, ST_HALTED: begin
                    if (start) begin
                        state <= ST_FETCH;
                        pc    <= RESET_PC;
                    end
                end
                ST_FETCH:   state <= ST_DECODE;
                ST_DECODE:  state <= ST_EXECUTE;
                ST_EXECUTE: state <= ST_MEMORY;
                ST_MEMORY:  state <= ST_WRITEBACK;
                ST_WRITEBACK: begin
                    pc    <= next_pc;
                    state <= (ir.opcode == OP_HALT) ? ST_HALTED : ST_FETCH;
                end
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_DECODE) begin
            ir <= instr;
        end
        if (state == ST_EXECUTE) begin
            result_q <= alu_result;
            taken_q  <= branch_cond;
        end
        if ((state == ST_MEMORY) && (ir.opcode == OP_LOAD)) begin
            result_q <= load_data;
        end
    end

    // ----------------------------------------
    // Operand selection
    // ----------------------------------------
    always_comb begin
        idx_a = ir.rs;
        idx_b = ir.rt;
        case (ir.opcode)
            OP_ADDI, OP_SUBI, OP_SHFTRI, OP_SHFTLI,
            OP_MOVL, OP_BR, OP_BRR: idx_a = ir.rd;
            OP_BRNZ, OP_STORE:      idx_b = ir.rd;
            // rt for the compare in execute, then rd as the target
            OP_BRGT: idx_b = (state == ST_EXECUTE) ? ir.rt : ir.rd;
            default: ;
        endcase
    end

    always_comb begin
        case (ir.opcode)
            OP_BRNZ: branch_cond = (op_a != '0);
            OP_BRGT: branch_cond = ($signed(op_a) > $signed(op_b));
            default: branch_cond = 1'b0;
        endcase
    end

    // ----------------------------------------
    // Next PC and data address
    // ----------------------------------------
    assign lit_ext  = {{(XLEN-LIT_W){ir.lit[LIT_W-1]}}, ir.lit};
    assign pc_plus4 = pc + ADDR_W'(4);

    always_comb begin
        case (ir.opcode)
            OP_BR:            next_pc = op_a[ADDR_W-1:0];
            OP_BRR:           next_pc = pc + op_a[ADDR_W-1:0];
            OP_BRRL:          next_pc = pc + lit_ext[ADDR_W-1:0];
            OP_BRNZ, OP_BRGT: next_pc = taken_q ? op_b[ADDR_W-1:0] : pc_plus4;
            default:          next_pc = pc_plus4;
        endcase
    end

    assign data_addr  = op_a[ADDR_W-1:0] + lit_ext[ADDR_W-1:0];
    assign store_en   = (state == ST_MEMORY) && (ir.opcode == OP_STORE);
    assign store_data = op_b;

    // ----------------------------------------
    // Writeback
    // ----------------------------------------
    always_comb begin
        case (ir.opcode)
            OP_AND, OP_OR, OP_XOR, OP_NOT,
            OP_SHFTR, OP_SHFTRI, OP_SHFTL, OP_SHFTLI,
            OP_LOAD, OP_MOV, OP_MOVL,
            OP_ADD, OP_ADDI, OP_SUB, OP_SUBI: writes_rd = 1'b1;
            default: writes_rd = 1'b0;
        endcase
    end

    assign wb_en   = (state == ST_WRITEBACK) && writes_rd && (ir.rd != '0);  // r0 stays zero
    assign wb_idx  = ir.rd;
    assign wb_data = result_q;
    assign halted  = (state == ST_HALTED);

endmodule

//--- hw/tinker_system.sv
// Tinker system top level
module tinker_system (
    input  logic                     clk,
    input  logic                     reset,
    input  tinker_bus_pkg::apb_req_t apb_req,
    output tinker_bus_pkg::apb_rsp_t apb_rsp,
    output logic                     halted
);
    import tinker_isa_pkg::*;
    import tinker_bus_pkg::*;

    core_state_e          state;
    logic                 start;
    mem_wr_t              mem_wr;
    logic [REG_IDX_W-1:0] host_idx;
    logic [XLEN-1:0]      host_data;
    instr_t               instr;
    logic [ADDR_W-1:0]    pc;
    logic [REG_IDX_W-1:0] idx_a;
    logic [REG_IDX_W-1:0] idx_b;
    logic [XLEN-1:0]      op_a;
    logic [XLEN-1:0]      op_b;
    logic [XLEN-1:0]      alu_result;
    logic [XLEN-1:0]      load_data;
    logic [ADDR_W-1:0]    data_addr;
    logic                 store_en;
    logic [XLEN-1:0]      store_data;
    logic                 wb_en;
    logic [REG_IDX_W-1:0] wb_idx;
    logic [XLEN-1:0]      wb_data;

    host_apb_port i_host (
        .clk, .reset, .apb_req, .apb_rsp, .state, .start, .mem_wr, .host_idx, .host_data
    );

    tinker_sequencer i_seq (
        .clk, .reset, .start, .instr, .pc, .state, .idx_a, .idx_b, .op_a, .op_b,
        .alu_result, .load_data, .data_addr, .store_en, .store_data,
        .wb_en, .wb_idx, .wb_data, .halted
    );

    // PC holds for the whole instruction, so the fetched word stays valid
    tinker_alu i_alu (
        .opcode (instr.opcode),
        .op_a,
        .op_b,
        .lit    (instr.lit),
        .result (alu_result)
    );

    tinker_regfile i_regs (
        .clk, .reset, .idx_a, .idx_b, .host_idx, .op_a, .op_b, .host_data,
        .wb_en, .wb_idx, .wb_data
    );

    tinker_memory i_mem (
        .clk, .pc, .instr, .data_addr, .load_data, .store_en, .store_data, .mem_wr
    );

endmodule

//--- sources.f
hw/tinker_isa_pkg.sv
hw/tinker_bus_pkg.sv
hw/host_apb_port.sv
hw/tinker_memory.sv
hw/tinker_regfile.sv
hw/tinker_alu.sv
hw/tinker_sequencer.sv
hw/tinker_system.sv
dv/tinker_tb.sv
